//--- rtl/task_unit_pkg.sv
/*
 * shared sizes, task records and enums of the timestamp-ordered task unit
 * register opcodes, dispatcher states, status word bit positions
 */
`default_nettype none

package task_unit_pkg;

   // task unit sizes
   localparam int N_TASK_TYPES = 4;
   localparam int TQ_STAGES    = 4;
   localparam int TQ_DEPTH     = 1 << TQ_STAGES;
   localparam int TS_W         = 8;
   localparam int OBJ_W        = 16;
   localparam int TTYPE_W      = 2;
   localparam int OCC_W        = TQ_STAGES + 1;

   // wishbone side
   localparam int WB_ADR_W     = 2;
   localparam int WB_DAT_W     = 32;
   localparam int ST_FULL_BIT  = 8;
   localparam int ST_EMPTY_BIT = 9;

   // one task as it travels to the outputs
   typedef struct packed {
      logic [TTYPE_W-1:0] ttype;
      logic [OBJ_W-1:0]   object;
      logic [TS_W-1:0]    ts;
   } task_t;

   // queue entry, task plus arrival tag
   typedef struct packed {
      task_t                tsk;
      logic [TQ_STAGES:0]   seq;
   } tq_elem_s;

   // register opcode, straight from wb_adr
   typedef enum logic [WB_ADR_W-1:0] {
      OP_TS     = 2'd0,
      OP_OBJECT = 2'd1,
      OP_PUSH   = 2'd2,
      OP_STATUS = 2'd3
   } ingress_op_e;

   typedef enum logic [1:0] {
      DS_IDLE,
      DS_LOAD,
      DS_PRESENT
   } disp_state_e;

endpackage

`default_nettype wire

//--- rtl/task_ingress.sv
/*
 * task_ingress: wishbone classic slave for task entry
 * stages timestamp and object id, pushes the task on OP_PUSH,
 * returns the queue status word on OP_STATUS
 */
`timescale 1ns/10ps
`default_nettype none

module task_ingress import task_unit_pkg::*; (
   input  logic                clk,
   input  logic                rst,
   // wishbone slave
   input  logic                wb_cyc,
   input  logic                wb_stb,
   input  logic                wb_we,
   input  logic [WB_ADR_W-1:0] wb_adr,
   input  logic [WB_DAT_W-1:0] wb_dat_w,
   output logic [WB_DAT_W-1:0] wb_dat_r,
   output logic                wb_ack,
   // push port into the queue
   output logic                push_valid,
   input  logic                push_ready,
   output task_t               push_task,
   // queue status
   input  logic [OCC_W-1:0]    occupancy,
   input  logic                full,
   input  logic                empty
);

   ingress_op_e         op;
   logic                active;
   logic                take;
   logic [TS_W-1:0]     stage_ts;
   logic [OBJ_W-1:0]    stage_obj;
   logic [WB_DAT_W-1:0] status_word;

   assign active = wb_cyc && wb_stb;
   assign op     = ingress_op_e'(wb_adr);
   // new request, not yet acked and no push in flight
   assign take   = active && !wb_ack && !push_valid;

   always_comb begin
      status_word = '0;
      status_word[OCC_W-1:0]    = occupancy;
      status_word[ST_FULL_BIT]  = full;
      status_word[ST_EMPTY_BIT] = empty;
   end

   // ack and push handshake
   always_ff @(posedge clk) begin
      if (rst) begin
         wb_ack     <= 1'b0;
         push_valid <= 1'b0;
      end else begin
         wb_ack <= 1'b0;
         if (push_valid) begin
            // bus cycle stays open until the queue takes the task
            if (push_ready) begin
               push_valid <= 1'b0;
               wb_ack     <= 1'b1;
            end
         end else if (take) begin
            if (wb_we && op == OP_PUSH)
               push_valid <= 1'b1;
            else
               wb_ack <= 1'b1;
         end
      end
   end

   // staged fields and read data
   always_ff @(posedge clk) begin
      if (take) begin
         if (wb_we) begin
            case (op)
               OP_TS:     stage_ts  <= wb_dat_w[TS_W-1:0];
               OP_OBJECT: stage_obj <= wb_dat_w[OBJ_W-1:0];
               OP_PUSH: begin
                  push_task.ttype  <= wb_dat_w[TTYPE_W-1:0];
                  push_task.object <= stage_obj;
                  push_task.ts     <= stage_ts;
               end
               default: ;
            endcase
         end else begin
            // only the status word reads back
            wb_dat_r <= (op == OP_STATUS) ? status_word : '0;
         end
      end
   end

endmodule

`default_nettype wire

//--- rtl/task_queue.sv
/*
 * task_queue: sorted-array priority queue, lowest timestamp at index 0
 * one push or one pop per cycle, pop wins, equal timestamps stay FIFO
 */
`timescale 1ns/10ps
`default_nettype none

module task_queue import task_unit_pkg::*; (
   input  logic             clk,
   input  logic             rst,
   // push side
   input  logic             push_valid,
   output logic             push_ready,
   input  task_t            push_task,
   // head side
   output logic             head_valid,
   output task_t            head_task,
   input  logic             pop,
   // status
   output logic [OCC_W-1:0] occupancy,
   output logic             full,
   output logic             empty
);

   tq_elem_s            q [TQ_DEPTH];
   tq_elem_s            new_elem;
   logic [OCC_W-1:0]    occ;
   logic [TQ_STAGES:0]  seq_cnt;
   // le[i]: entry i is live and not later than the new task
   logic [TQ_DEPTH-1:0] le;
   logic                do_push;
   logic                do_pop;

   assign full      = (occ == OCC_W'(TQ_DEPTH));
   assign empty     = (occ == '0);
   assign occupancy = occ;

   // a pop in the same cycle blocks the push
   assign push_ready = !full && !pop;
   assign do_push    = push_valid && push_ready;
   assign do_pop     = pop && !empty;

   assign head_valid = !empty;
   assign head_task  = q[0].tsk;

   assign new_elem.tsk = push_task;
   assign new_elem.seq = seq_cnt;

   // parallel compare against every slot
   // sorted array, so le is a run of ones from index 0
   always_comb begin
      for (int i = 0; i < TQ_DEPTH; i++) begin
         le[i] = (OCC_W'(i) < occ) && (q[i].tsk.ts <= push_task.ts);
      end
   end

   // entry array
   always_ff @(posedge clk) begin
      if (do_pop) begin
         // everything moves one place toward the head
         for (int i = 0; i < TQ_DEPTH - 1; i++) begin
            q[i] <= q[i+1];
         end
      end else if (do_push) begin
         // slot 0 has nothing in front of it
         if (!le[0])
            q[0] <= new_elem;
         for (int i = 1; i < TQ_DEPTH; i++) begin
            if (!le[i]) begin
               // first slot past the run takes the new task
               if (le[i-1])
                  q[i] <= new_elem;
               else
                  q[i] <= q[i-1];
            end
         end
      end
   end

   // occupancy and arrival counter
   always_ff @(posedge clk) begin
      if (rst) begin
         occ     <= '0;
         seq_cnt <= '0;
      end else if (do_pop) begin
         occ <= occ - 1'b1;
      end else if (do_push) begin
         occ     <= occ + 1'b1;
         // wraps, tags each arrival
         seq_cnt <= seq_cnt + 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- rtl/task_dispatch.sv
/*
 * task_dispatch: pops the queue head into a staging register
 * and offers it on the valid/ready port of its task type
 */
`timescale 1ns/10ps
`default_nettype none

module task_dispatch import task_unit_pkg::*; (
   input  logic                         clk,
   input  logic                         rst,
   // queue head
   input  logic                         head_valid,
   input  task_t                        head_task,
   output logic                         pop,
   // per-type output streams
   output logic  [0:N_TASK_TYPES-1]     m_rvalid,
   input  logic  [0:N_TASK_TYPES-1]     m_rready,
   output task_t [0:N_TASK_TYPES-1]     m_rdata
);

   disp_state_e               state;
   task_t                     stage;
   logic [0:N_TASK_TYPES-1]   sel;
   logic                      xfer;

   // port select from the staged type
   always_comb begin
      sel = '0;
      sel[stage.ttype] = 1'b1;
   end

   // staged task is offered in LOAD and PRESENT
   assign m_rvalid = (state != DS_IDLE) ? sel : '0;
   assign xfer     = |(m_rvalid & m_rready);

   // pop and load in the same cycle
   assign pop = (state == DS_IDLE) && head_valid;

   always_comb begin
      for (int i = 0; i < N_TASK_TYPES; i++) begin
         m_rdata[i] = sel[i] ? stage : '0;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= DS_IDLE;
      end else begin
         case (state)
            DS_IDLE: begin
               if (head_valid)
                  state <= DS_LOAD;
            end
            DS_LOAD: begin
               // first cycle on the port
               if (xfer)
                  state <= DS_IDLE;
               else
                  state <= DS_PRESENT;
            end
            DS_PRESENT: begin
               // held by back-pressure, everything behind waits
               if (xfer)
                  state <= DS_IDLE;
            end
            default: state <= DS_IDLE;
         endcase
      end
   end

   // staging register
   always_ff @(posedge clk) begin
      if (pop)
         stage <= head_task;
   end

endmodule

`default_nettype wire

//--- rtl/task_unit.sv
/*
 * task_unit: top level of the timestamp-ordered task unit
 * wishbone ingress -> sorted queue -> per-type dispatcher
 */
`timescale 1ns/10ps
`default_nettype none

module task_unit import task_unit_pkg::*; (
   input  logic                      clk,
   input  logic                      rst,
   // wishbone slave
   input  logic                      wb_cyc,
   input  logic                      wb_stb,
   input  logic                      wb_we,
   input  logic  [WB_ADR_W-1:0]      wb_adr,
   input  logic  [WB_DAT_W-1:0]      wb_dat_w,
   output logic  [WB_DAT_W-1:0]      wb_dat_r,
   output logic                      wb_ack,
   // per-type outputs
   output logic  [0:N_TASK_TYPES-1]  m_rvalid,
   input  logic  [0:N_TASK_TYPES-1]  m_rready,
   output task_t [0:N_TASK_TYPES-1]  m_rdata
);

   // ingress to queue
   logic             push_valid;
   logic             push_ready;
   task_t            push_task;
   // queue to dispatcher
   logic             head_valid;
   task_t            head_task;
   logic             pop;
   // queue status back to ingress
   logic [OCC_W-1:0] occupancy;
   logic             full;
   logic             empty;

   task_ingress i_task_ingress (
      .clk        (clk),
      .rst        (rst),
      .wb_cyc     (wb_cyc),
      .wb_stb     (wb_stb),
      .wb_we      (wb_we),
      .wb_adr     (wb_adr),
      .wb_dat_w   (wb_dat_w),
      .wb_dat_r   (wb_dat_r),
      .wb_ack     (wb_ack),
      .push_valid (push_valid),
      .push_ready (push_ready),
      .push_task  (push_task),
      .occupancy  (occupancy),
      .full       (full),
      .empty      (empty)
   );

   task_queue i_task_queue (
      .clk        (clk),
      .rst        (rst),
      .push_valid (push_valid),
      .push_ready (push_ready),
      .push_task  (push_task),
      .head_valid (head_valid),
      .head_task  (head_task),
      .pop        (pop),
      .occupancy  (occupancy),
      .full       (full),
      .empty      (empty)
   );

   task_dispatch i_task_dispatch (
      .clk        (clk),
      .rst        (rst),
      .head_valid (head_valid),
      .head_task  (head_task),
      .pop        (pop),
      .m_rvalid   (m_rvalid),
      .m_rready   (m_rready),
      .m_rdata    (m_rdata)
   );

endmodule

`default_nettype wire

//--- tests/task_unit_assertions.sv
/*
 * bound checker for the task unit
 * wishbone ack, output handshakes, queue pop and push rules
 */
`timescale 1ns/10ps
`default_nettype none

module task_unit_assertions import task_unit_pkg::*; (
   input logic                      clk,
   input logic                      rst,
   input logic                      wb_cyc,
   input logic                      wb_stb,
   input logic                      wb_ack,
   input logic  [0:N_TASK_TYPES-1]  m_rvalid,
   input logic  [0:N_TASK_TYPES-1]  m_rready,
   input task_t [0:N_TASK_TYPES-1]  m_rdata,
   input logic                      pop,
   input logic                      push_valid,
   input logic  [OCC_W-1:0]         occupancy,
   input logic                      full
);

   // ack only inside an open bus cycle
   ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
      wb_ack |-> (wb_cyc && wb_stb))
      else $error("wb_ack outside an active bus cycle");

   // at most one port offers a task
   one_port: assert property (@(posedge clk) disable iff (rst)
      $onehot0(m_rvalid))
      else $error("more than one output valid at once");

   // stalled port keeps valid and data
   hold_stalled: assert property (@(posedge clk) disable iff (rst)
      (|(m_rvalid & ~m_rready)) |=> ($stable(m_rvalid) && $stable(m_rdata)))
      else $error("output changed while stalled");

   // each pop removes one live entry
   pop_takes_one: assert property (@(posedge clk) disable iff (rst)
      pop |=> (occupancy == $past(occupancy) - 1'b1))
      else $error("pop did not remove exactly one queue entry");

   // waiting push leaves a full queue at capacity
   no_push_full: assert property (@(posedge clk) disable iff (rst)
      (full && push_valid && !pop) |=> (occupancy == OCC_W'(TQ_DEPTH)))
      else $error("push accepted while full");

endmodule

bind task_unit task_unit_assertions i_task_unit_assertions (.*);

`default_nettype wire

//--- tests/task_unit_tb.sv
/*
 * testbench for the task unit
 * reads the stim file, drives wishbone cycles and output ready,
 * checks status words and the order of released tasks
 */
`timescale 1ns/10ps
`default_nettype none

module task_unit_tb import task_unit_pkg::*; ();

   localparam int CLK_HALF   = 50;
   localparam int HOLD_CHECK = 8;

   logic                      clk;
   logic                      rst;
   logic                      wb_cyc;
   logic                      wb_stb;
   logic                      wb_we;
   logic [WB_ADR_W-1:0]       wb_adr;
   logic [WB_DAT_W-1:0]       wb_dat_w;
   logic [WB_DAT_W-1:0]       wb_dat_r;
   logic                      wb_ack;
   logic  [0:N_TASK_TYPES-1]  m_rvalid;
   logic  [0:N_TASK_TYPES-1]  m_rready;
   task_t [0:N_TASK_TYPES-1]  m_rdata;

   string lines[$];
   int    stim_lines;
   // push left open on a full queue
   logic  push_held;
   logic  held_acked;

   task_unit i_task_unit (
      .clk      (clk),
      .rst      (rst),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack),
      .m_rvalid (m_rvalid),
      .m_rready (m_rready),
      .m_rdata  (m_rdata)
   );

   always #CLK_HALF clk = ~clk;

   task automatic stop_run(input string msg);
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1, "stopping at the first failure");
   endtask

   // one clock, then 1 ns for sampling and driving
   task automatic tick();
      @(posedge clk);
      #1;
      if (push_held) begin
         // close the held push one cycle after its ack
         if (held_acked) begin
            wb_cyc     = 1'b0;
            wb_stb     = 1'b0;
            wb_we      = 1'b0;
            push_held  = 1'b0;
            held_acked = 1'b0;
         end else if (wb_ack) begin
            held_acked = 1'b1;
         end
      end
   endtask

   // single wishbone classic cycle, ends on the edge after ack
   task automatic bus_cycle(input logic we, input ingress_op_e op,
                            input logic [WB_DAT_W-1:0] data,
                            output logic [WB_DAT_W-1:0] rdata);
      while (push_held)
         tick();
      // idle cycle between bus cycles
      tick();
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = op;
      wb_dat_w = data;
      do
         tick();
      while (!wb_ack);
      rdata = wb_dat_r;
      tick();
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic enqueue_task(input task_t t);
      logic [WB_DAT_W-1:0] ignored;
      bus_cycle(1'b1, OP_TS, WB_DAT_W'(t.ts), ignored);
      bus_cycle(1'b1, OP_OBJECT, WB_DAT_W'(t.object), ignored);
      bus_cycle(1'b1, OP_PUSH, WB_DAT_W'(t.ttype), ignored);
   endtask

   task automatic check_status(input logic [OCC_W-1:0] want_occ,
                               input logic want_full, input logic want_empty);
      logic [WB_DAT_W-1:0] word;
      bus_cycle(1'b0, OP_STATUS, 32'h0, word);
      assert (word[OCC_W-1:0] == want_occ && word[ST_FULL_BIT] == want_full &&
              word[ST_EMPTY_BIT] == want_empty)
      else stop_run($sformatf(
         "MISMATCH at %0t: status occupancy %0d full %b empty %b, expected %0d %b %b",
         $time, word[OCC_W-1:0], word[ST_FULL_BIT], word[ST_EMPTY_BIT],
         want_occ, want_full, want_empty));
   endtask

   // push into a full queue, must stay without ack
   task automatic push_when_full(input task_t t);
      logic [WB_DAT_W-1:0] ignored;
      bus_cycle(1'b1, OP_TS, WB_DAT_W'(t.ts), ignored);
      bus_cycle(1'b1, OP_OBJECT, WB_DAT_W'(t.object), ignored);
      tick();
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = 1'b1;
      wb_adr   = OP_PUSH;
      wb_dat_w = WB_DAT_W'(t.ttype);
      repeat (HOLD_CHECK) begin
         tick();
         assert (!wb_ack)
         else stop_run($sformatf("MISMATCH at %0t: wb_ack for a push into a full queue",
                                 $time));
      end
      // finished by tick once a drain makes room
      push_held = 1'b1;
   endtask

   task automatic check_output(input task_t want);
      logic [0:N_TASK_TYPES-1] want_v;
      task_t                   got;
      int                      stall;
      want_v = '0;
      want_v[want.ttype] = 1'b1;
      got = '0;
      while (m_rvalid == '0)
         tick();
      for (int i = 0; i < N_TASK_TYPES; i++) begin
         if (m_rvalid[i])
            got = m_rdata[i];
      end
      assert (m_rvalid == want_v && got == want)
      else stop_run($sformatf(
         "MISMATCH at %0t: valid %b ttype %0d object %h ts %h, expected %b %0d %h %h",
         $time, m_rvalid, got.ttype, got.object, got.ts,
         want_v, want.ttype, want.object, want.ts));
      // random back-pressure on this port
      stall = int'($urandom_range(3, 0));
      repeat (stall)
         tick();
      m_rready[want.ttype] = 1'b1;
      tick();
      m_rready = '0;
   endtask

   // watchdog, 200 cycles per stim line
   initial begin
      wait (stim_lines > 0);
      repeat (stim_lines * 200) @(posedge clk);
      stop_run("run timed out before all stim lines were done");
   end

   initial begin
      int          fd;
      int          n;
      string       line;
      logic [7:0]  cmd;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      task_t       t;
      clk        = 1'b0;
      rst        = 1'b1;
      wb_cyc     = 1'b0;
      wb_stb     = 1'b0;
      wb_we      = 1'b0;
      wb_adr     = '0;
      wb_dat_w   = '0;
      m_rready   = '0;
      push_held  = 1'b0;
      held_acked = 1'b0;
      stim_lines = 0;
      void'($urandom(32'hfb5a03ca));

      fd = $fopen("tests/task_unit_stim.txt", "r");
      if (fd == 0)
         stop_run("could not open tests/task_unit_stim.txt");
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         // skip blank and comment lines
         if (n > 1 && line.getc(0) != "#")
            lines.push_back(line);
      end
      $fclose(fd);
      if (lines.size() == 0)
         stop_run("stim file holds no commands");
      stim_lines = lines.size();

      repeat (8) @(posedge clk);
      #1;
      rst = 1'b0;
      assert (m_rvalid == '0)
      else stop_run($sformatf("MISMATCH at %0t: m_rvalid %b after reset", $time, m_rvalid));

      foreach (lines[k]) begin
         cmd = lines[k].getc(0);
         n = $sscanf(lines[k].substr(2, lines[k].len() - 1), "%h %h %h", a, b, c);
         if (n != 3)
            stop_run($sformatf("malformed stim line: %s", lines[k]));
         t.ttype  = a[TTYPE_W-1:0];
         t.object = b[OBJ_W-1:0];
         t.ts     = c[TS_W-1:0];
         case (cmd)
            "W": enqueue_task(t);
            "R": check_output(t);
            "S": check_status(a[OCC_W-1:0], b[0], c[0]);
            "F": push_when_full(t);
            default: stop_run($sformatf("unknown stim command: %s", lines[k]));
         endcase
      end
      while (push_held)
         tick();

      $display("TEST OK");
      $finish;
   end

endmodule

`default_nettype wire

//--- flist.f
rtl/task_unit_pkg.sv
rtl/task_ingress.sv
rtl/task_queue.sv
rtl/task_dispatch.sv
rtl/task_unit.sv
tests/task_unit_assertions.sv
tests/task_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the task unit testbench with Verilator and runs it
# the exit status of the simulation is the result of the run
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f flist.f \
   --top-module task_unit_tb \
   --Mdir obj_dir \
   -o task_unit_sim

./obj_dir/task_unit_sim

//--- tests/task_unit_stim.txt
# W and F: ttype object ts, R: expected ttype object ts, all hex
# S: expected occupancy full empty, hex
# empty after reset
S 00 0 1
# batch, lowest ts first since it goes straight to staging
W 0 1000 05
W 2 1001 40
W 1 1002 20
S 02 0 0
W 3 1003 80
W 0 1004 20
W 1 1005 10
W 2 1006 f0
W 3 1007 20
W 0 1008 60
W 1 1009 30
W 2 100a 10
W 3 100b a0
W 0 100c 08
W 1 100d c0
W 2 100e 60
W 3 100f 30
W 0 1010 e0
# sixteen queued plus one staged
S 10 1 0
F 1 1011 30
R 0 1000 05
R 0 100c 08
# held push went in after the first drain
S 0f 0 0
R 1 1005 10
R 2 100a 10
R 1 1002 20
R 0 1004 20
R 3 1007 20
R 1 1009 30
R 3 100f 30
R 1 1011 30
R 2 1001 40
R 0 1008 60
R 2 100e 60
R 3 1003 80
R 3 100b a0
R 1 100d c0
R 0 1010 e0
R 2 1006 f0
S 00 0 1
